// File: build.f
logic/execPkg.sv
logic/hazardControl.sv
logic/operandSelect.sv
logic/alu.sv
logic/flagUnit.sv
logic/executeStage.sv
test/executeStage_sva.sv
test/executeStageTb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

SIM       ?= verilator
TOP       ?= executeStageTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/executeStageTb.sv
`timescale 1ns/10ps

module executeStageTb;

	import execPkg::*;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 16;
	localparam int directedCount = 24; // upper bound on directed vectors
	localparam int randomCount = 400;
	localparam int timeoutNs = (resetCycles + directedCount + randomCount + 50) * clkPeriod;
	localparam opcode_t nopOp = opcode_t'(4'b1111);

	logic        clk;
	logic        reset;
	issue_t      issue;
	exMemStage_t exMem;
	memWbStage_t memWb;
	execOut_t    execResult;
	flags_t      flagState;

	flags_t      modelFlags; // expected architectural flags
	integer      seed;
	int          resultErrors;
	int          flagErrors;
	int          checkedCount;
	exMemStage_t idleEx;
	memWbStage_t idleWb;

	executeStage UUT
	(
		.clk        (clk),
		.reset      (reset),
		.issue      (issue),
		.exMem      (exMem),
		.memWb      (memWb),
		.execResult (execResult),
		.flagState  (flagState)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// true when the instruction writes register r
	function automatic logic writesTarget(opcode_t op, regIdx_t ra, regIdx_t rb, regIdx_t rc,
		regIdx_t r);
		case (op)
			opAdd, opNand:
				return rc == r;
			opAdi:
				return rb == r;
			opLhi, opLw, opJal:
				return ra == r;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic writesFlags(opcode_t op);
		return op inside {opAdd, opNand, opAdi};
	endfunction

	// newest committed producer of register r
	function automatic word_t operandValue(regIdx_t r, word_t rfValue, exMemStage_t ex,
		memWbStage_t wb);
		if (ex.commit && !(ex.opcode inside {opLw, opJal})
			&& writesTarget(ex.opcode, ex.regA, ex.regB, ex.regC, r))
			return ex.result;
		if (wb.commit && writesTarget(wb.opcode, wb.regA, wb.regB, wb.regC, r))
		begin
			if (wb.opcode == opLw)
				return wb.loadData;
			else if (wb.opcode == opJal)
				return wb.pcPlusOne;
			else
				return wb.result;
		end
		return rfValue;
	endfunction

	function automatic execOut_t expectedOut(issue_t is, exMemStage_t ex, memWbStage_t wb,
		flags_t regFlags);
		word_t         a;
		word_t         b;
		logic [16:0]   sum;
		flags_t        condFlags;
		execOut_t      o;
		case (is.opcode)
			opAdd, opNand:
			begin
				a = operandValue(is.regA, is.valueA, ex, wb);
				b = operandValue(is.regB, is.valueB, ex, wb);
			end
			opAdi:
			begin
				a = operandValue(is.regA, is.valueA, ex, wb);
				b = is.immediate;
			end
			opLw, opSw:
			begin
				a = is.immediate;
				b = operandValue(is.regB, is.valueB, ex, wb);
			end
			default:
			begin
				a = is.valueA;
				b = is.valueB;
			end
		endcase
		sum = {1'b0, a} + {1'b0, b};
		if (is.opcode == opNand)
		begin
			o.result = ~(a & b);
			o.flags.carry = 1'b0;
		end
		else
		begin
			o.result = sum[15:0];
			o.flags.carry = sum[16];
		end
		o.flags.zero = (o.result == 16'h0000);
		if (ex.commit && writesFlags(ex.opcode))
			condFlags = ex.flags;
		else if (wb.commit && writesFlags(wb.opcode))
			condFlags = wb.flags;
		else
			condFlags = regFlags;
		case (is.cond)
			condCarry:
				o.commit = condFlags.carry;
			condZero:
				o.commit = condFlags.zero;
			default:
				o.commit = 1'b1;
		endcase
		return o;
	endfunction

	function automatic issue_t makeIssue(opcode_t op, cond_t c, regIdx_t ra, regIdx_t rb,
		regIdx_t rc, word_t va, word_t vb, word_t imm);
		issue_t v;
		v.opcode = op;
		v.cond = c;
		v.regA = ra;
		v.regB = rb;
		v.regC = rc;
		v.valueA = va;
		v.valueB = vb;
		v.immediate = imm;
		return v;
	endfunction

	function automatic exMemStage_t makeExMem(opcode_t op, regIdx_t ra, regIdx_t rb,
		regIdx_t rc, logic commit, word_t result, flags_t f);
		exMemStage_t v;
		v.opcode = op;
		v.cond = condNone;
		v.regA = ra;
		v.regB = rb;
		v.regC = rc;
		v.commit = commit;
		v.result = result;
		v.flags = f;
		return v;
	endfunction

	function automatic memWbStage_t makeMemWb(opcode_t op, regIdx_t ra, regIdx_t rb,
		regIdx_t rc, logic commit, word_t result, flags_t f, word_t loadData, word_t link);
		memWbStage_t v;
		v.opcode = op;
		v.cond = condNone;
		v.regA = ra;
		v.regB = rb;
		v.regC = rc;
		v.commit = commit;
		v.result = result;
		v.flags = f;
		v.loadData = loadData;
		v.pcPlusOne = link;
		return v;
	endfunction

	task automatic randomWord(output word_t w);
		integer r;
		r = $random(seed);
		case (r[3:2])
			2'd0: w = 16'h0000;
			2'd1: w = 16'hffff; // carry and zero corners
			default: w = r[31:16];
		endcase
	endtask

	task automatic randomOpcode(output opcode_t op);
		integer r;
		r = $random(seed);
		case (r[2:0])
			3'd0: op = opAdd;
			3'd1: op = opAdi;
			3'd2: op = opNand;
			3'd3: op = opLhi;
			3'd4: op = opLw;
			3'd5: op = opSw;
			3'd6: op = opJal;
			default: op = nopOp;
		endcase
	endtask

	task automatic randomStages(output issue_t is, output exMemStage_t ex,
		output memWbStage_t wb);
		integer r;
		r = $random(seed);
		randomOpcode(is.opcode);
		randomOpcode(ex.opcode);
		randomOpcode(wb.opcode);
		is.cond = (r[1:0] == 2'd1) ? condZero : (r[1:0] == 2'd2) ? condCarry : condNone;
		ex.cond = condNone;
		wb.cond = condNone;
		is.regA = regIdx_t'({1'b0, r[3:2]}); // registers 0..3 keep hazards frequent
		is.regB = regIdx_t'({1'b0, r[5:4]});
		is.regC = regIdx_t'({1'b0, r[7:6]});
		ex.regA = regIdx_t'({1'b0, r[9:8]});
		ex.regB = regIdx_t'({1'b0, r[11:10]});
		ex.regC = regIdx_t'({1'b0, r[13:12]});
		wb.regA = regIdx_t'({1'b0, r[15:14]});
		wb.regB = regIdx_t'({1'b0, r[17:16]});
		wb.regC = regIdx_t'({1'b0, r[19:18]});
		ex.commit = (r[21:20] != 2'd0);
		wb.commit = (r[23:22] != 2'd0);
		ex.flags = flags_t'(r[25:24]);
		wb.flags = flags_t'(r[27:26]);
		randomWord(is.valueA);
		randomWord(is.valueB);
		randomWord(is.immediate);
		randomWord(ex.result);
		randomWord(wb.result);
		randomWord(wb.loadData);
		randomWord(wb.pcPlusOne);
	endtask

	task automatic driveVector(issue_t is, exMemStage_t ex, memWbStage_t wb);
		@(posedge clk);
		issue <= is;
		exMem <= ex;
		memWb <= wb;
	endtask

	task automatic checkResult(execOut_t got, execOut_t exp);
		if (got !== exp)
		begin
			resultErrors++;
			$display("MISMATCH at %0t: execResult %h z%b c%b cm%b, expected %h z%b c%b cm%b",
				$time, got.result, got.flags.zero, got.flags.carry, got.commit,
				exp.result, exp.flags.zero, exp.flags.carry, exp.commit);
		end
	endtask

	task automatic checkFlags(flags_t got, flags_t exp);
		if (got !== exp)
		begin
			flagErrors++;
			$display("MISMATCH at %0t: flagState z%b c%b, expected z%b c%b",
				$time, got.zero, got.carry, exp.zero, exp.carry);
		end
	endtask

	// flag register model written from writeback
	always @(posedge clk)
	begin
		if (!reset)
			modelFlags <= '0;
		else if (memWb.commit && writesFlags(memWb.opcode))
			modelFlags <= memWb.flags;
	end

	always @(negedge clk)
	begin
		if (reset)
		begin
			checkResult(execResult, expectedOut(issue, exMem, memWb, modelFlags));
			checkFlags(flagState, modelFlags);
			checkedCount++;
		end
	end

	initial
	begin
		#(timeoutNs);
		$display("timeout: run did not finish within %0d ns", timeoutNs);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		issue_t      is;
		exMemStage_t ex;
		memWbStage_t wb;
		seed = 32'hd32d;
		resultErrors = 0;
		flagErrors = 0;
		checkedCount = 0;
		clk = 1'b0;
		reset = 1'b0;
		idleEx = makeExMem(nopOp, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0000, 2'b00);
		idleWb = makeMemWb(nopOp, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0000, 2'b00, 16'h0000, 16'h0000);
		issue = makeIssue(nopOp, condNone, 3'd0, 3'd0, 3'd0, 16'h0000, 16'h0000, 16'h0000);
		exMem = idleEx;
		memWb = idleWb;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b1;

		// plain add and nand, no hazards
		driveVector(makeIssue(opAdd, condNone, 1, 2, 3, 16'd3, 16'd5, 0), idleEx, idleWb);
		driveVector(makeIssue(opAdd, condNone, 1, 2, 3, 16'hffff, 16'h0001, 0), idleEx, idleWb);
		driveVector(makeIssue(opNand, condNone, 1, 2, 3, 16'hffff, 16'hffff, 0), idleEx, idleWb);
		driveVector(makeIssue(opNand, condNone, 1, 2, 3, 16'h0f0f, 16'h00ff, 0), idleEx, idleWb);

		// both later stages write r1
		is = makeIssue(opAdd, condNone, 1, 1, 4, 16'h1111, 16'h2222, 0);
		ex = makeExMem(opAdd, 0, 0, 1, 1'b1, 16'h0100, 2'b00);
		wb = makeMemWb(opLw, 1, 0, 0, 1'b1, 16'h0005, 2'b00, 16'h0040, 16'h0077);
		driveVector(is, ex, wb);
		ex.commit = 1'b0;
		driveVector(is, ex, wb); // load data
		wb.opcode = opJal;
		driveVector(is, ex, wb); // link value
		wb = makeMemWb(opAdd, 0, 0, 1, 1'b1, 16'h0333, 2'b00, 16'h0040, 16'h0077);
		driveVector(is, ex, wb);
		ex = makeExMem(opLw, 1, 0, 0, 1'b1, 16'h0999, 2'b00);
		driveVector(is, ex, idleWb); // load in exMem is not forwarded
		driveVector(is, ex, wb);

		// immediate operands
		driveVector(makeIssue(opAdi, condNone, 2, 5, 0, 16'h0010, 16'h0000, 16'hfff0),
			idleEx, idleWb);
		driveVector(makeIssue(opLw, condNone, 6, 3, 0, 16'h0000, 16'h0100, 16'h0005),
			idleEx, idleWb);
		driveVector(makeIssue(opSw, condNone, 6, 2, 0, 16'h0000, 16'h0100, 16'h0005),
			makeExMem(opAdi, 0, 2, 0, 1'b1, 16'h0200, 2'b00), idleWb);

		// conditional commit by flag source
		is = makeIssue(opAdd, condCarry, 1, 2, 3, 16'd1, 16'd2, 0);
		driveVector(is, makeExMem(opAdi, 0, 5, 0, 1'b1, 16'h0, 2'b01), idleWb);
		driveVector(is, makeExMem(opAdi, 0, 5, 0, 1'b0, 16'h0, 2'b01),
			makeMemWb(opNand, 0, 0, 6, 1'b1, 16'h0, 2'b00, 16'h0, 16'h0));
		is.cond = condZero;
		driveVector(is, idleEx, makeMemWb(opAdd, 0, 0, 6, 1'b1, 16'h0, 2'b10, 16'h0, 16'h0));
		driveVector(is, idleEx, idleWb); // zero now from flag register
		driveVector(is, idleEx, makeMemWb(opAdi, 0, 6, 0, 1'b1, 16'h0, 2'b01, 16'h0, 16'h0));
		driveVector(is, idleEx, idleWb);
		is.cond = condCarry;
		driveVector(is, idleEx, idleWb);

		for (int i = 0; i < randomCount; i++)
		begin
			randomStages(is, ex, wb);
			driveVector(is, ex, wb);
		end
		repeat (2) @(posedge clk);

		$display("checked %0d vectors, %0d result errors, %0d flag errors",
			checkedCount, resultErrors, flagErrors);
		if (checkedCount == 0)
			$display("no vectors were checked");
		if (resultErrors + flagErrors == 0 && checkedCount > 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: test/executeStage_sva.sv
`timescale 1ns/10ps

module executeStageChecks
(
	input logic              clk,
	input logic              reset,
	input execPkg::issue_t   issue,
	input execPkg::execOut_t execResult,
	input execPkg::flags_t   flagState,
	input logic              flagRegWrite
);

	import execPkg::*;

	// register is cleared by the reset edge
	assert property (@(posedge clk) !reset |=> (flagState == '0))
		else $error("flagState not cleared after reset");

	assert property (@(posedge clk) disable iff (!reset)
		!$past(flagRegWrite) |-> $stable(flagState))
		else $error("flagState changed without flagRegWrite");

	assert property (@(posedge clk) disable iff (!reset)
		(issue.opcode == opNand) |-> !execResult.flags.carry)
		else $error("carry set for nand");

endmodule

bind executeStage executeStageChecks checks
(
	.clk          (clk),
	.reset        (reset),
	.issue        (issue),
	.execResult   (execResult),
	.flagState    (flagState),
	.flagRegWrite (flagRegWrite)
);

// File: logic/executeStage.sv
`timescale 1ns/10ps

module executeStage
(
	input  logic                 clk,
	input  logic                 reset,
	input  execPkg::issue_t      issue,
	input  execPkg::exMemStage_t exMem,
	input  execPkg::memWbStage_t memWb,
	output execPkg::execOut_t    execResult,
	output execPkg::flags_t      flagState
);

	import execPkg::*;

	fwdSrc_t  fwdA;
	fwdSrc_t  fwdB;
	flagSrc_t flagSel;
	logic     flagRegWrite;
	word_t    aluIn1;
	word_t    aluIn2;
	word_t    aluResult;
	flags_t   aluFlags;
	logic     commit;

	hazardControl hazardCtl
	(
		.issue        (issue),
		.exMem        (exMem),
		.memWb        (memWb),
		.fwdA         (fwdA),
		.fwdB         (fwdB),
		.flagSel      (flagSel),
		.flagRegWrite (flagRegWrite)
	);

	operandSelect opSel
	(
		.issue  (issue),
		.exMem  (exMem),
		.memWb  (memWb),
		.fwdA   (fwdA),
		.fwdB   (fwdB),
		.aluIn1 (aluIn1),
		.aluIn2 (aluIn2)
	);

	alu aluUnit
	(
		.opcode (issue.opcode),
		.aluIn1 (aluIn1),
		.aluIn2 (aluIn2),
		.result (aluResult),
		.flags  (aluFlags)
	);

	flagUnit flags
	(
		.clk          (clk),
		.reset        (reset),
		.cond         (issue.cond),
		.flagSel      (flagSel),
		.flagRegWrite (flagRegWrite),
		.exMemFlags   (exMem.flags),
		.memWbFlags   (memWb.flags),
		.commit       (commit),
		.flagState    (flagState)
	);

	assign execResult = '{result: aluResult, flags: aluFlags, commit: commit};

endmodule

// File: logic/flagUnit.sv
`timescale 1ns/10ps

module flagUnit
(
	input  logic              clk,
	input  logic              reset,
	input  execPkg::cond_t    cond,
	input  execPkg::flagSrc_t flagSel,
	input  logic              flagRegWrite,
	input  execPkg::flags_t   exMemFlags,
	input  execPkg::flags_t   memWbFlags,
	output logic              commit,
	output execPkg::flags_t   flagState
);

	import execPkg::*;

	flags_t selFlags; // flags the condition is tested against

	// architectural flag register, written from writeback
	always_ff @(posedge clk)
	begin
		if (!reset)
			flagState <= '0;
		else if (flagRegWrite)
			flagState <= memWbFlags;
	end

	always_comb
	begin
		case (flagSel)
			flagExMem:
				selFlags = exMemFlags;
			flagMemWb:
				selFlags = memWbFlags;
			default:
				selFlags = flagState;
		endcase
	end

	always_comb
	begin
		case (cond)
			condCarry:
				commit = selFlags.carry;
			condZero:
				commit = selFlags.zero;
			default:
				commit = 1'b1; // unconditional
		endcase
	end

endmodule

// File: logic/alu.sv
`timescale 1ns/10ps

module alu
(
	input  execPkg::opcode_t opcode,
	input  execPkg::word_t   aluIn1,
	input  execPkg::word_t   aluIn2,
	output execPkg::word_t   result,
	output execPkg::flags_t  flags
);

	import execPkg::*;

	logic [wordWidth:0] sum; // extra bit holds carry-out
	word_t nandOut;
	logic  isNand;

	assign sum = {1'b0, aluIn1} + {1'b0, aluIn2};
	assign nandOut = ~(aluIn1 & aluIn2);
	assign isNand = (opcode == opNand);

	// everything that is not nand adds, addresses included
	assign result = isNand ? nandOut : sum[wordWidth-1:0];
	assign flags.carry = isNand ? 1'b0 : sum[wordWidth];
	assign flags.zero = (result == '0);

endmodule

// File: logic/operandSelect.sv
`timescale 1ns/10ps

module operandSelect
(
	input  execPkg::issue_t      issue,
	input  execPkg::exMemStage_t exMem,
	input  execPkg::memWbStage_t memWb,
	input  execPkg::fwdSrc_t     fwdA,
	input  execPkg::fwdSrc_t     fwdB,
	output execPkg::word_t       aluIn1,
	output execPkg::word_t       aluIn2
);

	import execPkg::*;

	// six-way word mux shared by both alu inputs
	function automatic word_t pickOperand(fwdSrc_t sel, word_t regValue, word_t imm,
		exMemStage_t ex, memWbStage_t wb);
		case (sel)
			srcImm:
				return imm;
			srcExMem:
				return ex.result;
			srcMemWbResult:
				return wb.result;
			srcMemWbLoad:
				return wb.loadData;
			srcMemWbLink:
				return wb.pcPlusOne;
			default:
				return regValue; // srcRegFile
		endcase
	endfunction

	assign aluIn1 = pickOperand(fwdA, issue.valueA, issue.immediate, exMem, memWb);
	assign aluIn2 = pickOperand(fwdB, issue.valueB, issue.immediate, exMem, memWb);

endmodule

// File: logic/hazardControl.sv
`timescale 1ns/10ps

module hazardControl
(
	input  execPkg::issue_t      issue,
	input  execPkg::exMemStage_t exMem,
	input  execPkg::memWbStage_t memWb,
	output execPkg::fwdSrc_t     fwdA,
	output execPkg::fwdSrc_t     fwdB,
	output execPkg::flagSrc_t    flagSel,
	output logic                 flagRegWrite
);

	import execPkg::*;

	logic    readsA;      // input A comes from a register
	logic    readsB;
	fwdSrc_t baseA;       // source when nothing is forwarded
	fwdSrc_t baseB;
	regIdx_t exMemDest;
	regIdx_t memWbDest;
	logic    exMemFwd;    // exMem result may be forwarded
	logic    memWbFwd;
	fwdSrc_t memWbKind;   // which memWb value carries the register
	logic    exMemFlagWr;
	logic    memWbFlagWr;

	function automatic fwdSrc_t pickSource(logic readsReg, fwdSrc_t base, logic exMemHit,
		logic memWbHit, fwdSrc_t wbKind);
		if (!readsReg)
			return base;
		else if (exMemHit)
			return srcExMem; // newest producer first
		else if (memWbHit)
			return wbKind;
		else
			return srcRegFile;
	endfunction

	// operand usage of the issued instruction
	always_comb
	begin
		readsA = 1'b0;
		readsB = 1'b0;
		baseA = srcRegFile;
		baseB = srcRegFile;
		case (issue.opcode)
			opAdd, opNand:
			begin
				readsA = 1'b1;
				readsB = 1'b1;
			end
			opAdi:
			begin
				readsA = 1'b1;
				baseB = srcImm;
			end
			opLw, opSw:
			begin
				baseA = srcImm; // address is imm + regB
				readsB = 1'b1;
			end
			default:
			begin
				baseA = srcRegFile; // lhi, jal and no-ops read nothing here
			end
		endcase
	end

	assign exMemDest = destReg(exMem.opcode, exMem.regA, exMem.regB, exMem.regC);
	assign memWbDest = destReg(memWb.opcode, memWb.regA, memWb.regB, memWb.regC);

	// loads and links in exMem have no value yet, stalling happens upstream
	assign exMemFwd = exMem.commit && writesReg(exMem.opcode)
		&& !(exMem.opcode inside {opLw, opJal});
	assign memWbFwd = memWb.commit && writesReg(memWb.opcode);

	always_comb
	begin
		case (memWb.opcode)
			opLw:
				memWbKind = srcMemWbLoad;
			opJal:
				memWbKind = srcMemWbLink;
			default:
				memWbKind = srcMemWbResult;
		endcase
	end

	assign fwdA = pickSource(readsA, baseA, exMemFwd && (exMemDest == issue.regA),
		memWbFwd && (memWbDest == issue.regA), memWbKind);
	assign fwdB = pickSource(readsB, baseB, exMemFwd && (exMemDest == issue.regB),
		memWbFwd && (memWbDest == issue.regB), memWbKind);

	assign exMemFlagWr = exMem.commit && isFlagWriter(exMem.opcode);
	assign memWbFlagWr = memWb.commit && isFlagWriter(memWb.opcode);

	always_comb
	begin
		if (exMemFlagWr)
			flagSel = flagExMem;
		else if (memWbFlagWr)
			flagSel = flagMemWb;
		else
			flagSel = flagReg;
	end

	assign flagRegWrite = memWbFlagWr; // flags retire from writeback

endmodule

// File: logic/execPkg.sv
package execPkg;

	localparam int wordWidth = 16;
	localparam int regIdxWidth = 3;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regIdxWidth-1:0] regIdx_t;

	// major opcode, unlisted codes behave as no-operation
	typedef enum logic [3:0] {
		opAdd  = 4'b0000,
		opAdi  = 4'b0001,
		opNand = 4'b0010,
		opLhi  = 4'b0011,
		opLw   = 4'b0100,
		opSw   = 4'b0101,
		opJal  = 4'b1000
	} opcode_t;

	typedef enum logic [1:0] {
		condNone  = 2'b00,
		condZero  = 2'b01,
		condCarry = 2'b10
	} cond_t;

	typedef struct packed {
		logic zero;
		logic carry;
	} flags_t;

	typedef enum logic [2:0] {
		srcRegFile,
		srcImm,
		srcExMem,
		srcMemWbResult,
		srcMemWbLoad,
		srcMemWbLink
	} fwdSrc_t;

	typedef enum logic [1:0] {
		flagReg,
		flagExMem,
		flagMemWb
	} flagSrc_t;

	typedef struct packed {
		opcode_t opcode;
		cond_t   cond;
		regIdx_t regA;
		regIdx_t regB;
		regIdx_t regC;
		word_t   valueA;    // as read from the register file
		word_t   valueB;
		word_t   immediate; // already sign-extended
	} issue_t;

	typedef struct packed {
		opcode_t opcode;
		cond_t   cond;
		regIdx_t regA;
		regIdx_t regB;
		regIdx_t regC;
		logic    commit;
		word_t   result; // alu result or load-high value
		flags_t  flags;
	} exMemStage_t;

	typedef struct packed {
		opcode_t opcode;
		cond_t   cond;
		regIdx_t regA;
		regIdx_t regB;
		regIdx_t regC;
		logic    commit;
		word_t   result;
		flags_t  flags;
		word_t   loadData;
		word_t   pcPlusOne; // link value of jump-and-link
	} memWbStage_t;

	typedef struct packed {
		word_t  result;
		flags_t flags;
		logic   commit;
	} execOut_t;

	// store and no-ops write no register
	function automatic logic writesReg(opcode_t op);
		case (op)
			opAdd, opNand, opAdi, opLhi, opLw, opJal:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic regIdx_t destReg(opcode_t op, regIdx_t regA, regIdx_t regB,
		regIdx_t regC);
		case (op)
			opAdd, opNand:
				return regC;
			opAdi:
				return regB;
			default:
				return regA; // lhi, lw, jal
		endcase
	endfunction

	function automatic logic isFlagWriter(opcode_t op);
		return (op == opAdd) || (op == opNand) || (op == opAdi);
	endfunction

endpackage
